//--- filelist.f
hw/routerPkg.sv
hw/inputQueue.sv
hw/packetTimer.sv
hw/outputArbiter.sv
hw/wbFlitMaster.sv
hw/routerOutputPort.sv
bench/routerOutputPort_properties.sv
bench/routerOutputPort_tb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and judges the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module routerOutputPort_tb \
  -o simv > sim.log 2>&1 && ./obj_dir/simv >> sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0

//--- bench/routerOutputPort_tb.sv
`timescale 1ns/1ns

module routerOutputPort_tb;
  import routerPkg::*;

  logic                     clk;
  logic                     rst;
  logic [numPorts-1:0]      inValid;
  logic [numPorts-1:0]      inReady;
  flitKind                  inKind [numPorts];
  logic [flitDataWidth-1:0] inData [numPorts];
  logic                     wbCyc;
  logic                     wbStb;
  logic                     wbWe;
  logic [wbAdrWidth-1:0]    wbAdr;
  logic [flitDataWidth-1:0] wbDat;
  logic                     wbAck;

  logic [34:0] expQ [numPorts][$]; // kind and data of every flit still owed.
  logic [numPorts-1:0] pushMask;
  logic holdSink;
  logic stallEnable;
  logic checkOrder;
  int errors;
  int expPort; // -1 while the output should be idle.
  int curPort;
  int remaining;
  int fullCycles;
  int flitsSeen;
  int ackDelay;
  int pktSeq;

  routerOutputPort u_routerOutputPort (
    .clk     (clk),
    .rst     (rst),
    .inValid (inValid),
    .inReady (inReady),
    .inKind  (inKind),
    .inData  (inData),
    .wbCyc   (wbCyc),
    .wbStb   (wbStb),
    .wbWe    (wbWe),
    .wbAdr   (wbAdr),
    .wbDat   (wbDat),
    .wbAck   (wbAck)
  );

  initial
  begin
    clk = 1'b0;
  end

  always #50 clk = ~clk;

  // round robin: first requester after lastPort, the search starts at L when idle.
  function automatic int expectedNextPort(int lastPort, logic [numPorts-1:0] mask);
    int startIdx;
    int idx;
    startIdx = (lastPort < 0) ? 0 : lastPort + 1;
    for (int k = 0; k < numPorts; k++)
    begin
      idx = (startIdx + k) % numPorts;
      if (mask[idx])
      begin
        return idx;
      end
    end
    return -1;
  endfunction

  function automatic logic [numPorts-1:0] pendingMask();
    logic [numPorts-1:0] mask;
    mask = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      mask[p] = (expQ[p].size() != 0);
    end
    return mask;
  endfunction

  task automatic checkTransfer();
    int port;
    logic [34:0] expFlit;
    port = int'(wbAdr[portIdWidth-1:0]);
    flitsSeen++;
    assert (wbCyc) else
    begin
      errors++;
      $display("mismatch at %0t: wbCyc got %b expected 1", $time, wbCyc);
    end
    assert (wbWe) else
    begin
      errors++;
      $display("mismatch at %0t: wbWe got %b expected 1", $time, wbWe);
    end
    assert (port < numPorts) else
    begin
      errors++;
      $display("a transfer at %0t names port %0d, which does not exist", $time, port);
    end
    if (port >= numPorts)
    begin
      return;
    end
    if (remaining != 0)
    begin
      assert (port == curPort) else
      begin
        errors++;
        $display("mismatch at %0t: wbAdr port got %0d expected %0d", $time, port, curPort);
      end
    end
    else if (checkOrder)
    begin
      assert (port == expPort) else
      begin
        errors++;
        $display("mismatch at %0t: wbAdr port got %0d expected %0d", $time, port, expPort);
      end
    end
    assert (expQ[port].size() != 0) else
    begin
      errors++;
      $display("port %0d sent a flit at %0t that was never written", port, $time);
    end
    if (expQ[port].size() == 0)
    begin
      return;
    end
    expFlit = expQ[port].pop_front();
    assert (wbAdr[wbAdrWidth-1:portIdWidth] == expFlit[34:32]) else
    begin
      errors++;
      $display("mismatch at %0t: wbAdr kind got %b expected %b", $time,
               wbAdr[wbAdrWidth-1:portIdWidth], expFlit[34:32]);
    end
    assert (wbDat == expFlit[31:0]) else
    begin
      errors++;
      $display("mismatch at %0t: wbDat got %h expected %h", $time, wbDat, expFlit[31:0]);
    end
    if (remaining == 0)
    begin
      curPort   = port;
      remaining = int'(expFlit[lengthWidth-1:0]);
    end
    remaining--;
    if (remaining <= 0)
    begin
      remaining = 0;
      expPort   = expectedNextPort(port, pendingMask()); // decided at the packet end.
    end
  endtask

  // accepted flits enter the model first, then the bus transfer is checked.
  always @(posedge clk)
  begin
    if (!rst)
    begin
      pushMask = '0;
      for (int p = 0; p < numPorts; p++)
      begin
        if (inValid[p] && !inReady[p])
        begin
          fullCycles++;
        end
        if (inValid[p] && inReady[p])
        begin
          expQ[p].push_back({inKind[p], inData[p]});
          pushMask[p] = 1'b1;
        end
      end
      if ((expPort < 0) && (remaining == 0) && (pushMask != '0))
      begin
        expPort = expectedNextPort(-1, pushMask);
      end
      if (wbStb && wbAck)
      begin
        checkTransfer();
      end
    end
  end

  // sink answers each strobe after 0 to 3 cycles when stalling is on.
  always @(posedge clk)
  begin
    #5;
    if (rst || wbAck)
    begin
      wbAck    = 1'b0;
      ackDelay = stallEnable ? int'($urandom_range(3, 0)) : 0;
    end
    else if (wbStb && !holdSink)
    begin
      if (ackDelay == 0)
      begin
        wbAck = 1'b1;
      end
      else
      begin
        ackDelay--;
      end
    end
  end

  // called 5 ns after a rising edge, and returns at the same phase.
  task automatic sendPacket(int port, int len);
    int waitCycles;
    for (int i = 0; i < len; i++)
    begin
      if (i == 0)
      begin
        inKind[port] = flitHeader;
        inData[port] = {4'(port), 16'(pktSeq), 12'(len)};
        pktSeq++;
      end
      else
      begin
        inKind[port] = (i == len - 1) ? flitTail : flitBody;
        inData[port] = $urandom();
      end
      inValid[port] = 1'b1;
      waitCycles = 0;
      @(posedge clk);
      while (!inReady[port] && (waitCycles < 1000))
      begin
        waitCycles++;
        @(posedge clk);
      end
      assert (waitCycles < 1000) else
      begin
        errors++;
        $display("port %0d could not write a flit for 1000 cycles", port);
      end
      #5;
    end
    inValid[port] = 1'b0;
  endtask

  task automatic sendStream(int port, int packets);
    for (int n = 0; n < packets; n++)
    begin
      sendPacket(port, int'($urandom_range(4, 1)));
    end
  endtask

  task automatic waitDrained();
    int waitCycles;
    waitCycles = 0;
    while ((pendingMask() != '0 || wbStb || remaining != 0) && (waitCycles < 5000))
    begin
      waitCycles++;
      @(posedge clk);
      #5;
    end
    assert (waitCycles < 5000) else
    begin
      errors++;
      $display("the output did not drain all written flits within 5000 cycles");
    end
  endtask

  initial
  begin
    void'($urandom(32'h774f));
    errors      = 0;
    expPort     = -1;
    curPort     = 0;
    remaining   = 0;
    fullCycles  = 0;
    flitsSeen   = 0;
    ackDelay    = 0;
    pktSeq      = 0;
    holdSink    = 1'b0;
    stallEnable = 1'b0;
    checkOrder  = 1'b1;
    rst         = 1'b1;
    inValid     = '0;
    wbAck       = 1'b0;
    for (int p = 0; p < numPorts; p++)
    begin
      inKind[p] = flitHeader;
      inData[p] = '0;
    end
    repeat (16) @(posedge clk);
    #5;
    rst = 1'b0;
    assert (!wbCyc) else
    begin
      errors++;
      $display("mismatch at %0t: wbCyc got %b expected 0", $time, wbCyc);
    end
    assert (!wbStb) else
    begin
      errors++;
      $display("mismatch at %0t: wbStb got %b expected 0", $time, wbStb);
    end
    assert (inReady == '1) else
    begin
      errors++;
      $display("mismatch at %0t: inReady got %b expected %b", $time, inReady,
               {numPorts{1'b1}});
    end

    for (int p = 0; p < numPorts; p++)
    begin
      sendPacket(p, 3);
      waitDrained();
    end

    holdSink = 1'b1; // every queue fills while the first flit waits.
    for (int p = 0; p < numPorts; p++)
    begin
      sendPacket(p, int'($urandom_range(4, 1)));
    end
    holdSink = 1'b0;
    waitDrained();

    holdSink = 1'b1;
    sendPacket(1, 3);
    sendPacket(4, 3);
    sendPacket(0, 3);
    holdSink = 1'b0;
    waitDrained();

    stallEnable = 1'b1;
    checkOrder  = 1'b0;
    fullCycles  = 0;
    fork
      sendStream(0, 6);
      sendStream(1, 6);
      sendStream(2, 6);
      sendStream(3, 6);
      sendStream(4, 6);
    join
    waitDrained();
    assert (fullCycles > 0) else
    begin
      errors++;
      $display("inReady never dropped although the queues should have filled");
    end

    $display("run complete, %0d flits checked, %0d errors", flitsSeen, errors);
    if (errors == 0)
    begin
      $display("TESTS PASSED");
    end
    else
    begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- bench/routerOutputPort_properties.sv
`timescale 1ns/1ns

module routerOutputPort_properties
  import routerPkg::*;
(
  input logic                     clk,
  input logic                     rst,
  input logic [5:0]               grant,
  input logic [numPorts-1:0]      popPort,
  input logic                     wbCyc,
  input logic                     wbStb,
  input logic                     wbAck,
  input logic [wbAdrWidth-1:0]    wbAdr,
  input logic [flitDataWidth-1:0] wbDat
);

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(grant))
    else $error("grant is not one-hot");

  stbInCycle: assert property (@(posedge clk) disable iff (rst) wbStb |-> wbCyc)
    else $error("wbStb is high outside a bus cycle");

  // a waiting strobe keeps its address and data.
  holdUntilAck: assert property (@(posedge clk) disable iff (rst)
    (wbStb && !wbAck) |=> (wbStb && $stable(wbAdr) && $stable(wbDat)))
    else $error("the transfer changed before its ack");

  // an ack pops exactly the queue named in the address.
  popOnAck: assert property (@(posedge clk) disable iff (rst)
    popPort == ((wbStb && wbAck) ? (numPorts'(1) << wbAdr[portIdWidth-1:0])
                                 : numPorts'(0)))
    else $error("a queue was popped outside an ack cycle or from the wrong port");

endmodule

bind wbFlitMaster routerOutputPort_properties u_routerOutputPort_properties (
  .clk     (clk),
  .rst     (rst),
  .grant   (grant),
  .popPort (popPort),
  .wbCyc   (wbCyc),
  .wbStb   (wbStb),
  .wbAck   (wbAck),
  .wbAdr   (wbAdr),
  .wbDat   (wbDat)
);

//--- hw/routerOutputPort.sv
`timescale 1ns/1ns

module routerOutputPort
  import routerPkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic [numPorts-1:0]      inValid,
  output logic [numPorts-1:0]      inReady,
  input  flitKind                  inKind [numPorts],
  input  logic [flitDataWidth-1:0] inData [numPorts],
  output logic                     wbCyc,
  output logic                     wbStb,
  output logic                     wbWe,
  output logic [wbAdrWidth-1:0]    wbAdr,
  output logic [flitDataWidth-1:0] wbDat,
  input  logic                     wbAck
);

  logic [numPorts-1:0]      headValid;
  flitKind                  headKind [numPorts];
  logic [flitDataWidth-1:0] headData [numPorts];
  logic [lengthWidth-1:0]   headLength [numPorts];
  logic [numPorts-1:0]      popPort;
  logic                     flitSent;
  grantState                grant;

  for (genvar i = 0; i < numPorts; i++)
  begin : genQueue
    inputQueue u_inputQueue (
      .clk       (clk),
      .rst       (rst),
      .inValid   (inValid[i]),
      .inReady   (inReady[i]),
      .inKind    (inKind[i]),
      .inData    (inData[i]),
      .pop       (popPort[i]),
      .headValid (headValid[i]),
      .headKind  (headKind[i]),
      .headData  (headData[i])
    );

    assign headLength[i] = headData[i][lengthWidth-1:0]; // only meaningful on a header.
  end

  outputArbiter u_outputArbiter (
    .clk        (clk),
    .rst        (rst),
    .req        (headValid),
    .headKind   (headKind),
    .headLength (headLength),
    .flitSent   (flitSent),
    .grant      (grant)
  );

  wbFlitMaster u_wbFlitMaster (
    .clk       (clk),
    .rst       (rst),
    .grant     (grant),
    .headValid (headValid),
    .headKind  (headKind),
    .headData  (headData),
    .popPort   (popPort),
    .flitSent  (flitSent),
    .wbCyc     (wbCyc),
    .wbStb     (wbStb),
    .wbWe      (wbWe),
    .wbAdr     (wbAdr),
    .wbDat     (wbDat),
    .wbAck     (wbAck)
  );

endmodule

//--- hw/wbFlitMaster.sv
`timescale 1ns/1ns

module wbFlitMaster
  import routerPkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  grantState                grant,
  input  logic [numPorts-1:0]      headValid,
  input  flitKind                  headKind [numPorts],
  input  logic [flitDataWidth-1:0] headData [numPorts],
  output logic [numPorts-1:0]      popPort,
  output logic                     flitSent,
  output logic                     wbCyc,
  output logic                     wbStb,
  output logic                     wbWe,
  output logic [wbAdrWidth-1:0]    wbAdr,
  output logic [flitDataWidth-1:0] wbDat,
  input  logic                     wbAck
);

  logic [portIdWidth-1:0] grantPort;
  logic                   grantValid;
  logic [portIdWidth-1:0] activePort; // port of the transfer on the bus.
  logic                   coolDown;
  logic                   launch;
  logic                   done;

  always_comb
  begin
    grantValid = 1'b1;
    grantPort  = '0;
    case (grant)
      stGrantL: grantPort = portIdWidth'(0);
      stGrantN: grantPort = portIdWidth'(1);
      stGrantE: grantPort = portIdWidth'(2);
      stGrantW: grantPort = portIdWidth'(3);
      stGrantS: grantPort = portIdWidth'(4);
      default:  grantValid = 1'b0;
    endcase
  end

  // the cycle after an ack is skipped so the arbiter can see the timer first.
  assign launch = grantValid && headValid[grantPort] && !wbStb && !coolDown;
  assign done   = wbStb && wbAck;

  assign flitSent = done;

  always_comb
  begin
    popPort = '0;
    if (done)
    begin
      popPort[activePort] = 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wbCyc      <= 1'b0;
      wbStb      <= 1'b0;
      wbWe       <= 1'b0;
      coolDown   <= 1'b0;
      activePort <= '0;
    end
    else
    begin
      coolDown <= done;
      if (done)
      begin
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe  <= 1'b0;
      end
      else if (launch)
      begin
        wbCyc      <= 1'b1;
        wbStb      <= 1'b1;
        wbWe       <= 1'b1;
        activePort <= grantPort;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (launch)
    begin
      wbAdr <= {headKind[grantPort], grantPort}; // held until the ack.
      wbDat <= headData[grantPort];
    end
  end

endmodule

//--- hw/outputArbiter.sv
`timescale 1ns/1ns

module outputArbiter
  import routerPkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [numPorts-1:0]    req,
  input  flitKind                headKind [numPorts],
  input  logic [lengthWidth-1:0] headLength [numPorts],
  input  logic                   flitSent,
  output grantState              grant
);

  grantState nextGrant;

  logic [numPorts-1:0]    timesUp;
  logic [portIdWidth-1:0] curPort;
  logic                   isIdle;
  logic [5:0]             nextBits;
  logic                   found;

  int baseIdx;
  int candidates;
  int searchIdx;

  for (genvar i = 0; i < numPorts; i++)
  begin : genTimer
    packetTimer u_packetTimer (
      .clk        (clk),
      .rst        (rst),
      .headKind   (headKind[i]),
      .headLength (headLength[i]),
      .granted    (grant[i+1]),
      .flitSent   (flitSent),
      .timesUp    (timesUp[i])
    );
  end

  always_comb
  begin
    isIdle  = 1'b0;
    curPort = '0;
    case (grant)
      stGrantL: curPort = portIdWidth'(0);
      stGrantN: curPort = portIdWidth'(1);
      stGrantE: curPort = portIdWidth'(2);
      stGrantW: curPort = portIdWidth'(3);
      stGrantS: curPort = portIdWidth'(4);
      default:  isIdle = 1'b1;
    endcase
  end

  // the holder never competes with itself, it passes through idle first.
  always_comb
  begin
    nextBits   = '0;
    found      = 1'b0;
    searchIdx  = 0;
    candidates = isIdle ? numPorts : numPorts - 1;
    baseIdx    = isIdle ? 0 : int'(curPort) + 1;
    if (!isIdle && req[curPort] && !timesUp[curPort])
    begin
      nextGrant = grant; // the packet in progress keeps the output.
    end
    else
    begin
      for (int k = 0; k < numPorts; k++)
      begin
        searchIdx = baseIdx + k;
        if (searchIdx >= numPorts)
        begin
          searchIdx = searchIdx - numPorts;
        end
        if (!found && (k < candidates) && req[searchIdx])
        begin
          found                 = 1'b1;
          nextBits[searchIdx+1] = 1'b1;
        end
      end
      nextGrant = found ? grantState'(nextBits) : stIdle;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= stIdle;
    end
    else
    begin
      grant <= nextGrant;
    end
  end

endmodule

//--- hw/packetTimer.sv
`timescale 1ns/1ns

module packetTimer
  import routerPkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  flitKind                headKind,
  input  logic [lengthWidth-1:0] headLength,
  input  logic                   granted,
  input  logic                   flitSent,
  output logic                   timesUp
);

  logic [lengthWidth-1:0] count; // flits sent of the current packet.
  logic [lengthWidth-1:0] limit;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
      limit <= '0;
    end
    else
    begin
      // only an idle timer loads, so a following header cannot move the limit.
      if ((count == '0) && (headKind == flitHeader))
      begin
        limit <= headLength;
      end
      if (!granted)
      begin
        count <= '0;
      end
      else if (flitSent)
      begin
        count <= count + 1'b1;
      end
    end
  end

  assign timesUp = (count == limit);

endmodule

//--- hw/inputQueue.sv
`timescale 1ns/1ns

module inputQueue
  import routerPkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     inValid,
  output logic                     inReady,
  input  flitKind                  inKind,
  input  logic [flitDataWidth-1:0] inData,
  input  logic                     pop,
  output logic                     headValid,
  output flitKind                  headKind,
  output logic [flitDataWidth-1:0] headData
);

  logic [flitDataWidth-1:0] dataMem [queueDepth];
  flitKind                  kindMem [queueDepth];

  logic [ptrWidth-1:0]   wrPtr;
  logic [ptrWidth-1:0]   rdPtr;
  logic [countWidth-1:0] count;

  logic push;
  logic doPop;

  assign headValid = (count != '0);
  assign doPop     = pop && headValid; // a pop on an empty queue is ignored.

  // a full queue still takes a flit in the cycle its head leaves.
  assign inReady = (count != countWidth'(queueDepth)) || doPop;
  assign push    = inValid && inReady;

  assign headKind = kindMem[rdPtr];
  assign headData = dataMem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      dataMem[wrPtr] <= inData;
      kindMem[wrPtr] <= inKind;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
      begin
        wrPtr <= wrPtr + 1'b1; // pointers wrap on their own.
      end
      if (doPop)
      begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({push, doPop})
        2'b10:
        begin
          count <= count + 1'b1;
        end
        2'b01:
        begin
          count <= count - 1'b1;
        end
        default:
        begin
          count <= count;
        end
      endcase
    end
  end

endmodule

//--- hw/routerPkg.sv
package routerPkg;

  // port order is L=0, N=1, E=2, W=3, S=4.
  localparam int numPorts = 5;

  localparam int flitDataWidth = 32;

  // the header carries the packet length in its low bits.
  localparam int lengthWidth = 12;

  localparam int queueDepth = 4; // must stay a power of two.

  localparam int portIdWidth = 3;

  localparam int ptrWidth = $clog2(queueDepth);

  localparam int countWidth = $clog2(queueDepth + 1); // holds 0 to queueDepth.

  localparam int wbAdrWidth = 6; // kind in the upper half, port in the lower half.

  typedef enum logic [2:0]
  {
    flitHeader = 3'b001,
    flitBody   = 3'b010,
    flitTail   = 3'b100
  } flitKind;

  // one-hot output grant, bit i+1 belongs to port i.
  typedef enum logic [5:0]
  {
    stIdle   = 6'b000001,
    stGrantL = 6'b000010,
    stGrantN = 6'b000100,
    stGrantE = 6'b001000,
    stGrantW = 6'b010000,
    stGrantS = 6'b100000
  } grantState;

endpackage
